/* project.f */
+incdir+include
design/mbox_pkg.sv
design/mbox_fifo.sv
design/mbox_port_frontend.sv
design/mbox_regfile.sv
design/mailbox_top.sv
test/mailbox_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       := mailbox_tb
FILELIST  := project.f
VFLAGS    := --binary --timing --assert -Wno-fatal -j 0
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
PASS_MSG  := Testbench passed
SRCS      := $(shell grep -v '^+' $(FILELIST)) include/mbox_defs.svh

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# status comes from the search for the pass message
run: compile
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* test/mailbox_tb.sv */
// mailbox testbench
`timescale 1ns/1ps
`include "mbox_defs.svh"

module mailbox_tb;
  import mbox_pkg::*;

  localparam int    MAX_ENTRIES = 80;
  localparam int    HS_MAX_CYC  = 12;   // req up to ack low, generous
  localparam int    GAP_MAX_CYC = 3;    // two lfsr bits
  localparam bit    PA = 1'b0;          // port select
  localparam bit    PB = 1'b1;
  localparam bit    RD = 1'b0;
  localparam bit    WR = 1'b1;
  localparam data_t WONLY = `MBOX_WRONLY_WORD;
  localparam data_t EMPTY = `MBOX_EMPTY_WORD;

  logic     clk, rst;
  logic     a_req, a_we, b_req, b_we;
  reg_idx_t a_addr, b_addr;
  data_t    a_wdata, b_wdata;
  logic     a_ack, a_err, a_irq, b_ack, b_err, b_irq;
  data_t    a_rdata, b_rdata;

  // stimulus table, one column per field
  string    t_name  [MAX_ENTRIES];
  bit       t_port  [MAX_ENTRIES];
  bit       t_we    [MAX_ENTRIES];
  reg_idx_t t_idx   [MAX_ENTRIES];
  data_t    t_wdata [MAX_ENTRIES];
  data_t    t_rdata [MAX_ENTRIES];    // compared on reads only
  bit       t_err   [MAX_ENTRIES];
  bit       t_irq   [MAX_ENTRIES];    // irq of the accessed port, after ack low

  int         n_entries;
  int         fail_cnt;
  logic [7:0] lfsr_q;
  bit         table_ready;

  mailbox_top DUT (
    .clk_i (clk), .rst_i (rst),
    .a_req_i (a_req), .a_we_i (a_we), .a_addr_i (a_addr), .a_wdata_i (a_wdata),
    .a_ack_o (a_ack), .a_rdata_o (a_rdata), .a_err_o (a_err), .a_irq_o (a_irq),
    .b_req_i (b_req), .b_we_i (b_we), .b_addr_i (b_addr), .b_wdata_i (b_wdata),
    .b_ack_o (b_ack), .b_rdata_o (b_rdata), .b_err_o (b_err), .b_irq_o (b_irq)
  );

  initial clk = 1'b0;
  always #4 clk = ~clk;                 // 8 ns period

  // ----------------------------------------------------------------------
  // helpers
  // ----------------------------------------------------------------------
  // x^8 + x^6 + x^5 + x^4 + 1
  function automatic logic [7:0] lfsr_next(logic [7:0] s);
    return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
  endfunction

  // idle cycles between handshakes, one step per bit
  function automatic int next_gap();
    int g;
    g = 0;
    for (int b = 0; b < 2; b++) begin
      lfsr_q = lfsr_next(lfsr_q);
      g      = g * 2 + int'(lfsr_q[0]);
    end
    return g;
  endfunction

  function automatic logic port_ack(bit p);
    return p ? b_ack : a_ack;
  endfunction

  function automatic void add_entry(string nm, bit port, bit we, reg_idx_t idx,
                                    data_t wd, data_t rd, bit er, bit iq);
    t_name[n_entries]  = nm;
    t_port[n_entries]  = port;
    t_we[n_entries]    = we;
    t_idx[n_entries]   = idx;
    t_wdata[n_entries] = wd;
    t_rdata[n_entries] = rd;
    t_err[n_entries]   = er;
    t_irq[n_entries]   = iq;
    n_entries++;
  endfunction

  // ----------------------------------------------------------------------
  // expected traffic, state carried from entry to entry
  // ----------------------------------------------------------------------
  task automatic build_table();
    // in order transfer, a to b then b to a
    for (int i = 1; i <= 5; i++)
      add_entry($sformatf("a_push_%0d", i), PA, WR, MBOXW, 32'hA000_0000 + i, '0, 0, 0);
    for (int i = 1; i <= 5; i++)
      add_entry($sformatf("b_pop_%0d", i), PB, RD, MBOXR, '0, 32'hA000_0000 + i, 0, 0);
    for (int i = 1; i <= 5; i++)
      add_entry($sformatf("b_push_%0d", i), PB, WR, MBOXW, 32'hB000_0000 + i, '0, 0, 0);
    for (int i = 1; i <= 5; i++)
      add_entry($sformatf("a_pop_%0d", i), PA, RD, MBOXR, '0, 32'hB000_0000 + i, 0, 0);
    // underflow, then overflow on the push past depth
    add_entry("a_pop_empty", PA, RD, MBOXR, '0, EMPTY, 1, 0);
    for (int i = 1; i <= `MBOX_DEPTH + 1; i++)
      add_entry($sformatf("a_fill_%0d", i), PA, WR, MBOXW, 32'hA000_0010 + i, '0,
                (i == `MBOX_DEPTH + 1), 0);
    add_entry("a_status_full", PA, RD, STATUS, '0, 32'h7, 0, 0);  // empty, full, wthr
    add_entry("a_error_rd1", PA, RD, ERROR, '0, 32'h3, 0, 0);
    add_entry("a_error_rd2", PA, RD, ERROR, '0, 32'h0, 0, 0);     // cleared by read
    // flush of a2b from the pushing side
    add_entry("a_ctrl_flush", PA, WR, CTRL, 32'h1, '0, 0, 0);
    add_entry("b_status_flushed", PB, RD, STATUS, '0, 32'h1, 0, 0);
    add_entry("b_pop_flushed", PB, RD, MBOXR, '0, EMPTY, 1, 0);
    add_entry("a_ctrl_rd", PA, RD, CTRL, '0, 32'h0, 0, 0);
    add_entry("b_error_rd", PB, RD, ERROR, '0, 32'h1, 0, 0);
    // thresholds and status
    add_entry("a_rirqt_wr", PA, WR, RIRQT, 32'd20, '0, 0, 0);
    add_entry("a_rirqt_rd", PA, RD, RIRQT, '0, 32'd7, 0, 0);      // clamped
    add_entry("b_rirqt_wr", PB, WR, RIRQT, 32'd2, '0, 0, 0);
    add_entry("b_rirqt_rd", PB, RD, RIRQT, '0, 32'd2, 0, 0);
    add_entry("a_push_t1", PA, WR, MBOXW, 32'hA000_0021, '0, 0, 0);
    add_entry("a_push_t2", PA, WR, MBOXW, 32'hA000_0022, '0, 0, 0);
    add_entry("b_status_2", PB, RD, STATUS, '0, 32'h0, 0, 0);     // 2 not above 2
    add_entry("a_push_t3", PA, WR, MBOXW, 32'hA000_0023, '0, 0, 0);
    add_entry("b_status_3", PB, RD, STATUS, '0, 32'h8, 0, 0);
    // interrupts at port b
    add_entry("b_irqs_all", PB, RD, IRQS, '0, 32'h7, 0, 0);       // both thr and error
    add_entry("b_irqs_clr_all", PB, WR, IRQS, 32'h7, '0, 0, 0);
    add_entry("b_irqs_rd", PB, RD, IRQS, '0, 32'h2, 0, 0);        // read thr set again
    add_entry("b_irqen_wr", PB, WR, IRQEN, 32'h2, '0, 0, 1);
    add_entry("b_irqp_rd", PB, RD, IRQP, '0, 32'h2, 0, 1);
    add_entry("b_pop_to_thr", PB, RD, MBOXR, '0, 32'hA000_0021, 0, 1);  // sticky
    add_entry("b_irqs_ack", PB, WR, IRQS, 32'h2, '0, 0, 0);
    add_entry("b_irqen_off", PB, WR, IRQEN, 32'h0, '0, 0, 0);
    add_entry("a_push_t4", PA, WR, MBOXW, 32'hA000_0024, '0, 0, 0);
    add_entry("b_irqs_masked", PB, RD, IRQS, '0, 32'h2, 0, 0);
    add_entry("b_irqp_masked", PB, RD, IRQP, '0, 32'h0, 0, 0);
    // decode
    add_entry("a_idx12_rd", PA, RD, reg_idx_t'(12), '0, 32'h0, 1, 0);
    add_entry("a_status_wr", PA, WR, STATUS, 32'h5, '0, 1, 0);
    add_entry("a_mboxw_rd", PA, RD, MBOXW, '0, WONLY, 0, 0);
    add_entry("b_mboxr_wr", PB, WR, MBOXR, 32'h1, '0, 1, 0);
    add_entry("b_idx15_rd", PB, RD, reg_idx_t'(15), '0, 32'h0, 1, 0);
  endtask

  // ----------------------------------------------------------------------
  // one four phase handshake plus checks
  // ----------------------------------------------------------------------
  task automatic run_entry(input int k);
    data_t got_rdata;
    logic  got_err, got_irq;
    bit    ok;
    int    gap;
    ok = 1'b1;
    @(posedge clk);
    if (t_port[k] == PA) begin
      a_req   <= 1'b1;
      a_we    <= t_we[k];
      a_addr  <= t_idx[k];
      a_wdata <= t_wdata[k];
    end else begin
      b_req   <= 1'b1;
      b_we    <= t_we[k];
      b_addr  <= t_idx[k];
      b_wdata <= t_wdata[k];
    end
    @(negedge clk);                     // outputs sampled mid cycle
    while (!port_ack(t_port[k])) @(negedge clk);
    got_rdata = t_port[k] ? b_rdata : a_rdata;
    got_err   = t_port[k] ? b_err : a_err;
    @(posedge clk);
    if (t_port[k] == PA) a_req <= 1'b0;
    else b_req <= 1'b0;
    @(negedge clk);
    while (port_ack(t_port[k])) @(negedge clk);
    got_irq = t_port[k] ? b_irq : a_irq;
    if (!t_we[k] && got_rdata !== t_rdata[k]) begin
      $display("MISMATCH %s rdata expected %h actual %h", t_name[k], t_rdata[k], got_rdata);
      ok = 1'b0;
    end
    if (got_err !== t_err[k]) begin
      $display("MISMATCH %s err expected %0b actual %0b", t_name[k], t_err[k], got_err);
      ok = 1'b0;
    end
    if (got_irq !== t_irq[k]) begin
      $display("MISMATCH %s irq expected %0b actual %0b", t_name[k], t_irq[k], got_irq);
      ok = 1'b0;
    end
    if (!ok) fail_cnt++;
    $display("%s %s", ok ? "ok  " : "FAIL", t_name[k]);
    gap = next_gap();
    repeat (gap) @(posedge clk);
  endtask

  // ----------------------------------------------------------------------
  // main sequence and watchdog
  // ----------------------------------------------------------------------
  initial begin
    rst     = 1'b1;
    a_req   = 1'b0;
    a_we    = 1'b0;
    a_addr  = '0;
    a_wdata = '0;
    b_req   = 1'b0;
    b_we    = 1'b0;
    b_addr  = '0;
    b_wdata = '0;
    n_entries = 0;
    fail_cnt  = 0;
    lfsr_q    = 8'd67;                  // seed
    build_table();
    table_ready = 1'b1;
    repeat (8) @(posedge clk);
    rst <= 1'b0;
    for (int k = 0; k < n_entries; k++) run_entry(k);
    $display("%0d entries run, %0d failed", n_entries, fail_cnt);
    if (fail_cnt == 0) $display("Testbench passed");
    else $display("Testbench failed");
    $finish;
  end

  initial begin : watchdog
    int limit;
    wait (table_ready);
    limit = 8 + n_entries * (HS_MAX_CYC + GAP_MAX_CYC) + 20;  // reset, traffic, slack
    repeat (limit) @(posedge clk);
    $display("watchdog expired after %0d cycles, a handshake never completed", limit);
    $display("Testbench failed");
    $finish;
  end

endmodule

/* design/mailbox_top.sv */
// two port mailbox
`timescale 1ns/1ps

module mailbox_top (
  input  logic               clk_i,
  input  logic               rst_i,
  // port a
  input  logic               a_req_i,
  input  logic               a_we_i,
  input  mbox_pkg::reg_idx_t a_addr_i,
  input  mbox_pkg::data_t    a_wdata_i,
  output logic               a_ack_o,
  output mbox_pkg::data_t    a_rdata_o,
  output logic               a_err_o,
  output logic               a_irq_o,
  // port b
  input  logic               b_req_i,
  input  logic               b_we_i,
  input  mbox_pkg::reg_idx_t b_addr_i,
  input  mbox_pkg::data_t    b_wdata_i,
  output logic               b_ack_o,
  output mbox_pkg::data_t    b_rdata_o,
  output logic               b_err_o,
  output logic               b_irq_o
);
  import mbox_pkg::*;

  // front end to bank, per port
  logic     a_acc, a_acc_we, a_acc_err;
  reg_idx_t a_acc_idx;
  data_t    a_acc_wdata, a_acc_rdata;
  logic     b_acc, b_acc_we, b_acc_err;
  reg_idx_t b_acc_idx;
  data_t    b_acc_wdata, b_acc_rdata;
  // bank to fifo control
  logic     a_push, a_pop, a_wr_flush, a_rd_flush;
  logic     b_push, b_pop, b_wr_flush, b_rd_flush;
  data_t    a_push_data, b_push_data;
  // fifo state back to the banks
  usage_t   a2b_usage, b2a_usage;
  data_t    a2b_rdata, b2a_rdata;    // head words

  // ----------------------------------------------------------------------
  // port a
  // ----------------------------------------------------------------------
  mbox_port_frontend fe_a (
    .clk_i, .rst_i,
    .req_i (a_req_i), .we_i (a_we_i), .addr_i (a_addr_i), .wdata_i (a_wdata_i),
    .ack_o (a_ack_o), .rdata_o (a_rdata_o), .err_o (a_err_o),
    .acc_o (a_acc), .acc_we_o (a_acc_we), .acc_idx_o (a_acc_idx),
    .acc_wdata_o (a_acc_wdata), .acc_rdata_i (a_acc_rdata), .acc_err_i (a_acc_err)
  );

  mbox_regfile regs_a (
    .clk_i, .rst_i,
    .acc_i (a_acc), .we_i (a_acc_we), .idx_i (a_acc_idx), .wdata_i (a_acc_wdata),
    .rdata_o (a_acc_rdata), .err_o (a_acc_err),
    .wr_usage_i (a2b_usage), .push_o (a_push), .push_data_o (a_push_data),
    .wr_flush_o (a_wr_flush),
    .rd_data_i (b2a_rdata), .rd_usage_i (b2a_usage), .pop_o (a_pop),
    .rd_flush_o (a_rd_flush),
    .irq_o (a_irq_o)
  );

  // ----------------------------------------------------------------------
  // port b
  // ----------------------------------------------------------------------
  mbox_port_frontend fe_b (
    .clk_i, .rst_i,
    .req_i (b_req_i), .we_i (b_we_i), .addr_i (b_addr_i), .wdata_i (b_wdata_i),
    .ack_o (b_ack_o), .rdata_o (b_rdata_o), .err_o (b_err_o),
    .acc_o (b_acc), .acc_we_o (b_acc_we), .acc_idx_o (b_acc_idx),
    .acc_wdata_o (b_acc_wdata), .acc_rdata_i (b_acc_rdata), .acc_err_i (b_acc_err)
  );

  mbox_regfile regs_b (
    .clk_i, .rst_i,
    .acc_i (b_acc), .we_i (b_acc_we), .idx_i (b_acc_idx), .wdata_i (b_acc_wdata),
    .rdata_o (b_acc_rdata), .err_o (b_acc_err),
    .wr_usage_i (b2a_usage), .push_o (b_push), .push_data_o (b_push_data),
    .wr_flush_o (b_wr_flush),
    .rd_data_i (a2b_rdata), .rd_usage_i (a2b_usage), .pop_o (b_pop),
    .rd_flush_o (b_rd_flush),
    .irq_o (b_irq_o)
  );

  // ----------------------------------------------------------------------
  // crossing fifos, pushed on one side and popped on the other
  // ----------------------------------------------------------------------
  mbox_fifo fifo_a2b (
    .clk_i, .rst_i,
    .push_i (a_push), .pop_i (b_pop),
    .wflush_i (a_wr_flush), .rflush_i (b_rd_flush),
    .wdata_i (a_push_data), .rdata_o (a2b_rdata), .usage_o (a2b_usage)
  );

  mbox_fifo fifo_b2a (
    .clk_i, .rst_i,
    .push_i (b_push), .pop_i (a_pop),
    .wflush_i (b_wr_flush), .rflush_i (a_rd_flush),
    .wdata_i (b_push_data), .rdata_o (b2a_rdata), .usage_o (b2a_usage)
  );

endmodule

/* design/mbox_regfile.sv */
// mailbox register bank
`timescale 1ns/1ps
`include "mbox_defs.svh"

module mbox_regfile (
  input  logic               clk_i,
  input  logic               rst_i,
  // access from the port front end
  input  logic               acc_i,
  input  logic               we_i,
  input  mbox_pkg::reg_idx_t idx_i,
  input  mbox_pkg::data_t    wdata_i,
  output mbox_pkg::data_t    rdata_o,     // combinational response
  output logic               err_o,
  // write fifo, this port pushes
  input  mbox_pkg::usage_t   wr_usage_i,
  output logic               push_o,
  output mbox_pkg::data_t    push_data_o,
  output logic               wr_flush_o,
  // read fifo, this port pops
  input  mbox_pkg::data_t    rd_data_i,
  input  mbox_pkg::usage_t   rd_usage_i,
  output logic               pop_o,
  output logic               rd_flush_o,
  // level interrupt, active high
  output logic               irq_o
);
  import mbox_pkg::*;

  logic [1:0] error_q, error_d;   // bit0 empty pop, bit1 full push
  usage_t     wirqt_q, wirqt_d;   // write usage threshold
  usage_t     rirqt_q, rirqt_d;   // read usage threshold
  irq_vec_t   irqs_q,  irqs_d;    // interrupt status
  irq_vec_t   irqen_q, irqen_d;   // interrupt enable
  logic [3:0] status;             // built from fifo usage
  irq_vec_t   irqp;               // pending = status & enable
  logic [1:0] ctrl;               // flush strobes as read back
  logic       wr_full, rd_empty;
  logic       dec_valid;          // index inside the register map
  logic       ctrl_wr;

  // thresholds saturate at depth-1 so a full fifo still crosses them
  function automatic usage_t clamp_thr(data_t val);
    if (val >= data_t'(`MBOX_DEPTH)) begin
      return usage_t'(`MBOX_DEPTH - 1);
    end
    return usage_t'(val);
  endfunction

  // ----------------------------------------------------------------------
  // combinational registers
  // ----------------------------------------------------------------------
  assign wr_full  = wr_usage_i[`MBOX_CNT_W];   // full flag on top of usage
  assign rd_empty = (rd_usage_i == '0);
  assign status   = {rd_usage_i > rirqt_q,     // bit3 read above threshold
                     wr_usage_i > wirqt_q,     // bit2 write above threshold
                     wr_full,
                     rd_empty};
  assign irqp     = irqs_q & irqen_q;
  assign irq_o    = |irqp;

  assign dec_valid   = (idx_i < reg_idx_t'(`MBOX_NUM_REGS));
  assign ctrl_wr     = acc_i & we_i & (idx_i == CTRL);
  assign wr_flush_o  = ctrl_wr & wdata_i[0];
  assign rd_flush_o  = ctrl_wr & wdata_i[1];
  assign ctrl        = {rd_flush_o, wr_flush_o}; // only nonzero during a ctrl write
  assign push_data_o = wdata_i;                  // full words, no strobes

  // ----------------------------------------------------------------------
  // access decode and next state
  // ----------------------------------------------------------------------
  always_comb begin
    error_d = error_q;
    wirqt_d = wirqt_q;
    rirqt_d = rirqt_q;
    irqs_d  = irqs_q;
    irqen_d = irqen_q;
    rdata_o = '0;
    err_o   = 1'b0;
    push_o  = 1'b0;
    pop_o   = 1'b0;

    // threshold status is sticky until acknowledged
    if (status[2]) irqs_d[0] = 1'b1;
    if (status[3]) irqs_d[1] = 1'b1;

    if (acc_i) begin
      if (!dec_valid) begin
        err_o = 1'b1;                   // outside the map, rdata stays 0
      end else if (!we_i) begin
        unique case (reg_e'(idx_i))
          MBOXW:  rdata_o = `MBOX_WRONLY_WORD;
          MBOXR: begin
            if (!rd_empty) begin
              rdata_o = rd_data_i;
              pop_o   = 1'b1;
            end else begin
              rdata_o    = `MBOX_EMPTY_WORD;
              err_o      = 1'b1;
              error_d[0] = 1'b1;        // underflow
              irqs_d[2]  = 1'b1;
            end
          end
          STATUS: rdata_o = data_t'(status);
          ERROR: begin
            rdata_o = data_t'(error_q);
            error_d = '0;               // cleared by the read
          end
          WIRQT:  rdata_o = data_t'(wirqt_q);
          RIRQT:  rdata_o = data_t'(rirqt_q);
          IRQS:   rdata_o = data_t'(irqs_q);
          IRQEN:  rdata_o = data_t'(irqen_q);
          IRQP:   rdata_o = data_t'(irqp);
          CTRL:   rdata_o = data_t'(ctrl);
          default: err_o = 1'b1;
        endcase
      end else begin
        unique case (reg_e'(idx_i))
          MBOXW: begin
            if (!wr_full) begin
              push_o = 1'b1;
            end else begin
              err_o      = 1'b1;
              error_d[1] = 1'b1;        // overflow
              irqs_d[2]  = 1'b1;
            end
          end
          WIRQT:  wirqt_d = clamp_thr(wdata_i);
          RIRQT:  rirqt_d = clamp_thr(wdata_i);
          // write one to clear, applied after the threshold set above
          IRQS:   irqs_d  = irqs_d & ~wdata_i[2:0];
          IRQEN:  irqen_d = wdata_i[2:0];
          CTRL:   ;                     // flush strobes come from ctrl_wr
          default: err_o = 1'b1;        // MBOXR STATUS ERROR IRQP are read only
        endcase
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      error_q <= '0;
      wirqt_q <= '0;
      rirqt_q <= '0;
      irqs_q  <= '0;
      irqen_q <= '0;
    end else begin
      error_q <= error_d;
      wirqt_q <= wirqt_d;
      rirqt_q <= rirqt_d;
      irqs_q  <= irqs_d;
      irqen_q <= irqen_d;
    end
  end

  // fifo usage stays within depth so the full flag and threshold compares hold
  a_usage_range: assert property (@(posedge clk_i) disable iff (rst_i)
    (wr_usage_i <= usage_t'(`MBOX_DEPTH)) && (rd_usage_i <= usage_t'(`MBOX_DEPTH)))
    else $error("fifo usage above the fifo depth");

endmodule

/* design/mbox_port_frontend.sv */
// mailbox port front end
`timescale 1ns/1ps

module mbox_port_frontend (
  input  logic               clk_i,
  input  logic               rst_i,
  // requester side, four phase req/ack
  input  logic               req_i,
  input  logic               we_i,
  input  mbox_pkg::reg_idx_t addr_i,
  input  mbox_pkg::data_t    wdata_i,
  output logic               ack_o,
  output mbox_pkg::data_t    rdata_o,     // held while ack is high
  output logic               err_o,
  // register bank side
  output logic               acc_o,       // one cycle strobe per handshake
  output logic               acc_we_o,
  output mbox_pkg::reg_idx_t acc_idx_o,
  output mbox_pkg::data_t    acc_wdata_o,
  input  mbox_pkg::data_t    acc_rdata_i, // same cycle response
  input  logic               acc_err_i
);
  import mbox_pkg::*;

  hs_state_e state_q, state_d;
  logic      we_q;                      // captured request
  reg_idx_t  idx_q;
  data_t     wdata_q;
  data_t     rdata_q;                   // latched response
  logic      err_q;
  logic      ack_q;

  // ----------------------------------------------------------------------
  // handshake fsm
  // ----------------------------------------------------------------------
  always_comb begin
    state_d = state_q;
    unique case (state_q)
      IDLE:    if (req_i) state_d = ACCESS;
      ACCESS:  state_d = RESPOND;       // access happens exactly once
      RESPOND: if (!req_i) state_d = RELEASE;
      RELEASE: state_d = IDLE;          // ack low for at least a cycle
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= IDLE;
      ack_q   <= 1'b0;
      err_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      if (state_q == ACCESS) begin
        ack_q <= 1'b1;                  // rises together with the response
        err_q <= acc_err_i;
      end else if (state_q == RESPOND && !req_i) begin
        ack_q <= 1'b0;
      end
    end
  end

  // request capture on entry, read data latched in the access cycle
  always_ff @(posedge clk_i) begin
    if (state_q == IDLE && req_i) begin
      we_q    <= we_i;
      idx_q   <= addr_i;
      wdata_q <= wdata_i;
    end
    if (state_q == ACCESS) begin
      rdata_q <= acc_rdata_i;
    end
  end

  assign acc_o       = (state_q == ACCESS);
  assign acc_we_o    = we_q;
  assign acc_idx_o   = idx_q;
  assign acc_wdata_o = wdata_q;

  assign ack_o   = ack_q;
  assign rdata_o = rdata_q;
  assign err_o   = err_q;

  // ----------------------------------------------------------------------
  // protocol checks
  // ----------------------------------------------------------------------
  // requester keeps the request fields steady for the whole handshake
  a_req_stable: assert property (@(posedge clk_i) disable iff (rst_i)
    req_i ##1 req_i |-> $stable(addr_i) && $stable(we_i))
    else $error("request fields changed while req is high");

  a_no_ack_idle: assert property (@(posedge clk_i) disable iff (rst_i)
    (state_q == IDLE) |-> !ack_o)
    else $error("ack high while the port is idle");

endmodule

/* design/mbox_fifo.sv */
// mailbox fifo
`timescale 1ns/1ps
`include "mbox_defs.svh"

module mbox_fifo (
  input  logic             clk_i,
  input  logic             rst_i,
  input  logic             push_i,    // from the writing bank
  input  logic             pop_i,     // from the reading bank
  input  logic             wflush_i,  // flush requested by the writing side
  input  logic             rflush_i,  // flush requested by the reading side
  input  mbox_pkg::data_t  wdata_i,
  output mbox_pkg::data_t  rdata_o,   // head word, valid when not empty
  output mbox_pkg::usage_t usage_o    // {full, count}
);
  import mbox_pkg::*;

  localparam logic [`MBOX_CNT_W-1:0] LAST_PTR = `MBOX_CNT_W'(`MBOX_DEPTH - 1);

  data_t                  mem_q [`MBOX_DEPTH];  // storage, no reset
  logic [`MBOX_CNT_W-1:0] wptr_q, rptr_q;
  usage_t                 cnt_q;                // words held, 0..depth
  logic                   full, empty;
  logic                   flush;
  logic                   do_push, do_pop;

  assign flush   = wflush_i | rflush_i;         // either side may drop the contents
  assign full    = (cnt_q == usage_t'(`MBOX_DEPTH));
  assign empty   = (cnt_q == '0);
  assign do_push = push_i & ~full;              // bank checks usage, guard anyway
  assign do_pop  = pop_i & ~empty;

  // ----------------------------------------------------------------------
  // pointers and count
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (rst_i || flush) begin                   // flush beats a same cycle push
      wptr_q <= '0;
      rptr_q <= '0;
      cnt_q  <= '0;
    end else begin
      if (do_push) begin
        wptr_q <= (wptr_q == LAST_PTR) ? '0 : wptr_q + 1'b1;
      end
      if (do_pop) begin
        rptr_q <= (rptr_q == LAST_PTR) ? '0 : rptr_q + 1'b1;
      end
      unique case ({do_push, do_pop})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;                // idle, or push and pop together
      endcase
    end
  end

  // storage write
  always_ff @(posedge clk_i) begin
    if (do_push && !flush) begin
      mem_q[wptr_q] <= wdata_i;
    end
  end

  assign rdata_o = mem_q[rptr_q];
  // full flag on top, low bits of the count below it
  assign usage_o = {full, cnt_q[`MBOX_CNT_W-1:0]};

  // ----------------------------------------------------------------------
  // the register banks turn overflow and underflow into error responses
  // ----------------------------------------------------------------------
  a_no_push_full: assert property (@(posedge clk_i) disable iff (rst_i)
    push_i |-> !full)
    else $error("push into a full mailbox fifo");

  a_no_pop_empty: assert property (@(posedge clk_i) disable iff (rst_i)
    pop_i |-> !empty)
    else $error("pop from an empty mailbox fifo");

endmodule

/* design/mbox_pkg.sv */
// mailbox types
`include "mbox_defs.svh"

package mbox_pkg;

  // ----------------------------------------------------------------------
  // plain vectors
  // ----------------------------------------------------------------------
  typedef logic [`MBOX_DATA_W-1:0] data_t;     // register and mailbox word
  typedef logic [`MBOX_IDX_W-1:0]  reg_idx_t;  // register index on a port

  // fifo usage, msb is the full flag so threshold compares stay sane
  // when the fifo holds all of its words
  typedef logic [`MBOX_CNT_W:0]    usage_t;

  // bit0 write threshold, bit1 read threshold, bit2 error
  typedef logic [2:0]              irq_vec_t;

  // ----------------------------------------------------------------------
  // enums
  // ----------------------------------------------------------------------
  typedef enum logic [`MBOX_IDX_W-1:0] {
    MBOXW  = `MBOX_REG_MBOXW,
    MBOXR  = `MBOX_REG_MBOXR,
    STATUS = `MBOX_REG_STATUS,
    ERROR  = `MBOX_REG_ERROR,
    WIRQT  = `MBOX_REG_WIRQT,
    RIRQT  = `MBOX_REG_RIRQT,
    IRQS   = `MBOX_REG_IRQS,
    IRQEN  = `MBOX_REG_IRQEN,
    IRQP   = `MBOX_REG_IRQP,
    CTRL   = `MBOX_REG_CTRL
  } reg_e;

  // port handshake phases
  typedef enum logic [1:0] {
    IDLE,     // waiting for req
    ACCESS,   // one cycle register access
    RESPOND,  // ack high until req drops
    RELEASE   // ack low, one cycle gap
  } hs_state_e;

endpackage

/* include/mbox_defs.svh */
// mailbox shared definitions
`ifndef MBOX_DEFS_SVH
`define MBOX_DEFS_SVH

// word and register index widths
`define MBOX_DATA_W      32
`define MBOX_IDX_W       4

// fifo geometry, same in both directions
`define MBOX_DEPTH       8     // words per fifo, at least 2
`define MBOX_CNT_W       3     // count bits, full flag sits above them

// register map
`define MBOX_NUM_REGS    10
`define MBOX_REG_MBOXW   4'd0  // push word
`define MBOX_REG_MBOXR   4'd1  // pop word
`define MBOX_REG_STATUS  4'd2
`define MBOX_REG_ERROR   4'd3
`define MBOX_REG_WIRQT   4'd4  // write usage threshold
`define MBOX_REG_RIRQT   4'd5  // read usage threshold
`define MBOX_REG_IRQS    4'd6
`define MBOX_REG_IRQEN   4'd7
`define MBOX_REG_IRQP    4'd8
`define MBOX_REG_CTRL    4'd9

// fixed read-back words
`define MBOX_WRONLY_WORD 32'hFEEDC0DE  // MBOXW is write only
`define MBOX_EMPTY_WORD  32'hFEEDDEAD  // MBOXR read with nothing queued

`endif
